//--- tb.f
hw/axi_wr_pkg.sv
hw/aw_arbiter.sv
hw/slave_port.sv
hw/default_slave.sv
hw/b_return.sv
hw/axi_wr_xbar.sv
dv/axi_slave_model.sv
dv/tb_axi_wr_xbar.sv

//--- dv/tb_axi_wr_xbar.sv
module tb_axi_wr_xbar;
  timeunit 1ns;
  timeprecision 1ps;
  import axi_wr_pkg::*;

  localparam int N_ROWS = 9;
  localparam int CLK_P  = 100;

  logic                 clk;
  logic                 rstn;
  aw_m_t                m_aw [N_MASTERS];
  logic [N_MASTERS-1:0] m_aw_valid;
  logic [N_MASTERS-1:0] m_aw_ready;
  w_t                   m_w [N_MASTERS];
  logic [N_MASTERS-1:0] m_w_valid;
  logic [N_MASTERS-1:0] m_w_ready;
  b_m_t                 m_b [N_MASTERS];
  logic [N_MASTERS-1:0] m_b_valid;
  logic [N_MASTERS-1:0] m_b_ready;
  aw_s_t                s_aw [N_SLAVES-1];
  logic [1:0]           s_aw_valid;
  logic [1:0]           s_aw_ready;
  w_t                   s_w [N_SLAVES-1];
  logic [1:0]           s_w_valid;
  logic [1:0]           s_w_ready;
  b_s_t                 s_b [N_SLAVES-1];
  logic [1:0]           s_b_valid;
  logic [1:0]           s_b_ready;

  // Stimulus table
  string      t_name [N_ROWS];
  int         t_m    [N_ROWS];
  axi_addr_t  t_addr [N_ROWS];
  axi_len_t   t_len  [N_ROWS];
  axi_data_t  t_seed [N_ROWS];
  slave_sel_t t_sel  [N_ROWS];
  axi_resp_t  t_resp [N_ROWS];
  logic       t_conc [N_ROWS];
  logic       t_hold [N_ROWS];

  int errors;
  int row_err [N_ROWS];
  int passed;
  int failed;
  int first_gnt;

  axi_wr_xbar uut (
    .clk        (clk),
    .rstn       (rstn),
    .m_aw       (m_aw),
    .m_aw_valid (m_aw_valid),
    .m_aw_ready (m_aw_ready),
    .m_w        (m_w),
    .m_w_valid  (m_w_valid),
    .m_w_ready  (m_w_ready),
    .m_b        (m_b),
    .m_b_valid  (m_b_valid),
    .m_b_ready  (m_b_ready),
    .s_aw       (s_aw),
    .s_aw_valid (s_aw_valid),
    .s_aw_ready (s_aw_ready),
    .s_w        (s_w),
    .s_w_valid  (s_w_valid),
    .s_w_ready  (s_w_ready),
    .s_b        (s_b),
    .s_b_valid  (s_b_valid),
    .s_b_ready  (s_b_ready)
  );

  axi_slave_model u_s0 (
    .clk (clk), .rstn (rstn),
    .aw (s_aw[0]), .aw_valid (s_aw_valid[0]), .aw_ready (s_aw_ready[0]),
    .w (s_w[0]), .w_valid (s_w_valid[0]), .w_ready (s_w_ready[0]),
    .b (s_b[0]), .b_valid (s_b_valid[0]), .b_ready (s_b_ready[0])
  );

  axi_slave_model u_s1 (
    .clk (clk), .rstn (rstn),
    .aw (s_aw[1]), .aw_valid (s_aw_valid[1]), .aw_ready (s_aw_ready[1]),
    .w (s_w[1]), .w_valid (s_w_valid[1]), .w_ready (s_w_ready[1]),
    .b (s_b[1]), .b_valid (s_b_valid[1]), .b_ready (s_b_ready[1])
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_P / 2) clk = ~clk;
  end

  initial begin
    #(N_ROWS * 300 * CLK_P);
    $display("Run timed out before all tests finished");
    $display("Some tests failed");
    $finish;
  end

  // First AW handshake after reset
  always @(negedge clk) begin
    if (rstn && first_gnt < 0) begin
      for (int m = 0; m < N_MASTERS; m++) begin
        if (m_aw_valid[m] && m_aw_ready[m]) begin
          first_gnt = m;
        end
      end
    end
  end

  task automatic add_row(input int r, input string name, input int m, input axi_addr_t addr,
                         input axi_len_t len, input axi_data_t seed, input slave_sel_t sel,
                         input axi_resp_t resp, input logic conc, input logic hold);
    t_name[r] = name;
    t_m[r]    = m;
    t_addr[r] = addr;
    t_len[r]  = len;
    t_seed[r] = seed;
    t_sel[r]  = sel;
    t_resp[r] = resp;
    t_conc[r] = conc;
    t_hold[r] = hold;
  endtask

  function automatic axi_id_t row_id(input int r);
    return axi_id_t'(r * 3 + 1);
  endfunction

  function automatic axi_data_t beat_data(input int r, input int k);
    return t_seed[r] + axi_data_t'(k) * 32'h0101_0101;
  endfunction

  task automatic note_failure(input int r, input string msg);
    $display("[ERROR] %s: %s", t_name[r], msg);
    errors++;
    row_err[r]++;
  endtask

  task automatic check_sel(input int r, input slave_sel_t exp, input slave_sel_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: slave expected %0d, actual %0d", t_name[r], exp, act);
      errors++;
      row_err[r]++;
    end
  endtask

  task automatic check_resp(input int r, input axi_resp_t exp, input axi_resp_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: resp expected %0d, actual %0d", t_name[r], exp, act);
      errors++;
      row_err[r]++;
    end
  endtask

  task automatic check_id(input int r, input string what, input axi_id_t exp, input axi_id_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: %s expected %0h, actual %0h", t_name[r], what, exp, act);
      errors++;
      row_err[r]++;
    end
  endtask

  task automatic check_data(input int r, input int k, input axi_data_t exp, input axi_data_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: beat %0d expected %h, actual %h", t_name[r], k, exp, act);
      errors++;
      row_err[r]++;
    end
  endtask

  task automatic check_addr(input int r, input axi_addr_t exp, input axi_addr_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: addr expected %h, actual %h", t_name[r], exp, act);
      errors++;
      row_err[r]++;
    end
  endtask

  // Called right after a rising edge
  task automatic present_aw(input int m, input int r);
    aw_m_t a;
    a.id       = row_id(r);
    a.addr     = t_addr[r];
    a.len      = t_len[r];
    a.size     = 3'd2;
    a.burst    = 2'b01;
    m_aw[m]       <= a;
    m_aw_valid[m] <= 1'b1;
  endtask

  task automatic finish_aw(input int m);
    do @(negedge clk); while (!m_aw_ready[m]);
    @(posedge clk);
    m_aw_valid[m] <= 1'b0;
  endtask

  task automatic send_w(input int m, input int r);
    w_t beat;
    for (int k = 0; k <= int'(t_len[r]); k++) begin
      beat.data    = beat_data(r, k);
      beat.last    = (k == int'(t_len[r]));
      m_w[m]       <= beat;
      m_w_valid[m] <= 1'b1;
      do @(negedge clk); while (!m_w_ready[m]);
      @(posedge clk);
    end
    m_w_valid[m] <= 1'b0;
  endtask

  task automatic take_b(input int m, output b_m_t b);
    do @(negedge clk); while (!(m_b_valid[m] && m_b_ready[m]));
    b = m_b[m];
    @(posedge clk);
  endtask

  task automatic check_model(input int r, input slave_sel_t sel);
    axi_addr_t addr;
    axi_ids_t  id;
    int        n;
    axi_data_t d [16];
    if (sel == 0) begin
      addr = u_s0.last_addr;
      id   = u_s0.last_id;
      n    = u_s0.n_beats;
      for (int k = 0; k < 16; k++) d[k] = u_s0.data[k];
    end else begin
      addr = u_s1.last_addr;
      id   = u_s1.last_id;
      n    = u_s1.n_beats;
      for (int k = 0; k < 16; k++) d[k] = u_s1.data[k];
    end
    check_addr(r, t_addr[r], addr);
    check_id(r, "slave id", row_id(r), id[ID_W-1:0]);
    if (int'(id[IDS_W-1]) != t_m[r]) begin
      $display("[ERROR] %s: id master bit expected %0d, actual %0d", t_name[r], t_m[r],
               id[IDS_W-1]);
      errors++;
      row_err[r]++;
    end
    if (n != int'(t_len[r]) + 1) begin
      $display("[ERROR] %s: beats up to last expected %0d, actual %0d", t_name[r],
               int'(t_len[r]) + 1, n);
      errors++;
      row_err[r]++;
    end
    for (int k = 0; k <= int'(t_len[r]); k++) begin
      check_data(r, k, beat_data(r, k), d[k]);
    end
  endtask

  task automatic check_row(input int r, input b_m_t b, input int c0, input int c1);
    slave_sel_t obs;
    int         m;
    m = t_m[r];
    if (u_s0.aw_cnt[m] != c0) begin
      obs = 2'd0;
    end else if (u_s1.aw_cnt[m] != c1) begin
      obs = 2'd1;
    end else begin
      obs = 2'd2;
    end
    check_sel(r, t_sel[r], obs);
    check_id(r, "b id", row_id(r), b.id);
    check_resp(r, t_resp[r], b.resp);
    if (t_resp[r] == RESP_OKAY && obs == t_sel[r]) begin
      check_model(r, obs);
    end
  endtask

  task automatic run_row(input int r);
    int   m;
    int   c0;
    int   c1;
    b_m_t b;
    m  = t_m[r];
    c0 = u_s0.aw_cnt[m];
    c1 = u_s1.aw_cnt[m];
    @(posedge clk);
    present_aw(m, r);
    finish_aw(m);
    send_w(m, r);
    take_b(m, b);
    check_row(r, b, c0, c1);
  endtask

  // Second write must wait for the first B
  task automatic run_hold(input int r);
    int   m;
    int   c0;
    int   c1;
    int   early;
    b_m_t b;
    m     = t_m[r];
    c0    = u_s0.aw_cnt[m];
    c1    = u_s1.aw_cnt[m];
    early = 0;
    @(posedge clk);
    m_b_ready[m] <= 1'b0;
    present_aw(m, r);
    finish_aw(m);
    send_w(m, r);
    do @(negedge clk); while (!m_b_valid[m]);
    @(posedge clk);
    present_aw(m, r);
    repeat (4) begin
      @(negedge clk);
      if (m_aw_ready[m]) early++;
    end
    if (early > 0) note_failure(r, "second write was accepted while its B was still pending");
    @(posedge clk);
    m_b_ready[m] <= 1'b1;
    take_b(m, b);
    check_row(r, b, c0, c1);
    c0 = u_s0.aw_cnt[m];
    c1 = u_s1.aw_cnt[m];
    finish_aw(m);
    send_w(m, r);
    take_b(m, b);
    check_row(r, b, c0, c1);
  endtask

  task automatic report_row(input int r);
    if (row_err[r] == 0) begin
      $display("PASS %s", t_name[r]);
      passed++;
    end else begin
      $display("FAIL %s", t_name[r]);
      failed++;
    end
  endtask

  initial begin
    int i;
    int reset_err;
    errors     = 0;
    passed     = 0;
    failed     = 0;
    first_gnt  = -1;
    rstn       = 1'b0;
    m_aw_valid = '0;
    m_w_valid  = '0;
    m_b_ready  = '1;
    for (int m = 0; m < N_MASTERS; m++) begin
      m_aw[m] = '0;
      m_w[m]  = '0;
    end
    for (int r = 0; r < N_ROWS; r++) row_err[r] = 0;

    add_row(0, "conc_m0_slv0", 0, 32'h0000_1000, 8'd3, 32'hA000_0001, 2'd0, RESP_OKAY, 1, 0);
    add_row(1, "conc_m1_slv1", 1, 32'h0001_2000, 8'd3, 32'hB000_0002, 2'd1, RESP_OKAY, 0, 0);
    add_row(2, "m0_slv0", 0, 32'h0000_0100, 8'd0, 32'h1000_0001, 2'd0, RESP_OKAY, 0, 0);
    add_row(3, "m1_slv1", 1, 32'h0001_0200, 8'd0, 32'h2000_0002, 2'd1, RESP_OKAY, 0, 0);
    add_row(4, "m0_unmapped", 0, 32'h0002_0000, 8'd1, 32'h3000_0003, 2'd2, RESP_DECERR, 0, 0);
    add_row(5, "m1_unmapped", 1, 32'h8000_0000, 8'd0, 32'h4000_0004, 2'd2, RESP_DECERR, 0, 0);
    add_row(6, "m0_burst_slv1", 0, 32'h0001_0400, 8'd7, 32'h5000_0005, 2'd1, RESP_OKAY, 0, 0);
    add_row(7, "m1_burst_slv0", 1, 32'h0000_0800, 8'd5, 32'h6000_0006, 2'd0, RESP_OKAY, 0, 0);
    add_row(8, "m1_outstanding", 1, 32'h0000_3000, 8'd1, 32'h7000_0007, 2'd0, RESP_OKAY, 0, 1);

    repeat (3) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    reset_err = 0;
    if (m_aw_ready !== '0 || m_b_valid !== '0 || s_aw_valid !== '0) begin
      $display("[ERROR] reset_idle: ready and valid outputs expected %b %b %b, actual %b %b %b",
               2'b00, 2'b00, 2'b00, m_aw_ready, m_b_valid, s_aw_valid);
      errors++;
      reset_err++;
    end
    if (reset_err == 0) begin
      $display("PASS reset_idle");
      passed++;
    end else begin
      $display("FAIL reset_idle");
      failed++;
    end

    i = 0;
    while (i < N_ROWS) begin
      if (t_conc[i]) begin
        fork
          run_row(i);
          run_row(i + 1);
        join
        if (i == 0 && first_gnt != 0) begin
          $display("[ERROR] %s: first grant expected 0, actual %0d", t_name[i], first_gnt);
          errors++;
          row_err[i]++;
        end
        report_row(i);
        report_row(i + 1);
        i = i + 2;
      end else begin
        if (t_hold[i]) begin
          run_hold(i);
        end else begin
          run_row(i);
        end
        report_row(i);
        i = i + 1;
      end
    end

    $display("Tests: %0d passed, %0d failed", passed, failed);
    if (errors == 0 && failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- dv/axi_slave_model.sv
module axi_slave_model (
  input  logic              clk,
  input  logic              rstn,
  input  axi_wr_pkg::aw_s_t aw,
  input  logic              aw_valid,
  output logic              aw_ready,
  input  axi_wr_pkg::w_t    w,
  input  logic              w_valid,
  output logic              w_ready,
  output axi_wr_pkg::b_s_t  b,
  output logic              b_valid,
  input  logic              b_ready
);
  timeunit 1ns;
  timeprecision 1ps;
  import axi_wr_pkg::*;

  logic [31:0] rnd;
  logic        aw_rnd;
  logic        w_rnd;
  logic        aw_pend;
  logic        w_done;
  int          wr_ptr;

  // Records of the last write, read by the testbench
  axi_addr_t   last_addr;
  axi_ids_t    last_id;
  axi_data_t   data [16];
  int          n_beats;
  int          aw_cnt [N_MASTERS];

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // One write held at a time until its B is taken
  assign aw_ready = aw_rnd & ~aw_pend;
  assign w_ready  = w_rnd & ~w_done;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      rnd     <= 32'd80100;
      aw_rnd  <= 1'b0;
      w_rnd   <= 1'b0;
      aw_pend <= 1'b0;
      w_done  <= 1'b0;
      b_valid <= 1'b0;
      b       <= '0;
      wr_ptr  <= 0;
      n_beats <= 0;
      for (int m = 0; m < N_MASTERS; m++) begin
        aw_cnt[m] <= 0;
      end
    end else begin
      rnd    <= xorshift(rnd);
      aw_rnd <= rnd[0] | rnd[1];
      w_rnd  <= rnd[2] | rnd[3];
      if (aw_valid && aw_ready) begin
        aw_pend                 <= 1'b1;
        last_addr               <= aw.addr;
        last_id                 <= aw.id;
        aw_cnt[aw.id[IDS_W-1]]  <= aw_cnt[aw.id[IDS_W-1]] + 1;
      end
      if (w_valid && w_ready) begin
        data[wr_ptr[3:0]] <= w.data;
        if (w.last) begin
          w_done  <= 1'b1;
          n_beats <= wr_ptr + 1;
          wr_ptr  <= 0;
        end else begin
          wr_ptr <= wr_ptr + 1;
        end
      end
      if (b_valid && b_ready) begin
        b_valid <= 1'b0;
        aw_pend <= 1'b0;
        w_done  <= 1'b0;
      end else if (aw_pend && w_done && !b_valid) begin
        b_valid <= 1'b1;
        b.id    <= last_id;
        b.resp  <= RESP_OKAY;
      end
    end
  end

endmodule

//--- hw/axi_wr_xbar.sv
module axi_wr_xbar (
  input  logic                             clk,
  input  logic                             rstn,
  // Masters
  input  axi_wr_pkg::aw_m_t                m_aw       [axi_wr_pkg::N_MASTERS],
  input  logic [axi_wr_pkg::N_MASTERS-1:0] m_aw_valid,
  output logic [axi_wr_pkg::N_MASTERS-1:0] m_aw_ready,
  input  axi_wr_pkg::w_t                   m_w        [axi_wr_pkg::N_MASTERS],
  input  logic [axi_wr_pkg::N_MASTERS-1:0] m_w_valid,
  output logic [axi_wr_pkg::N_MASTERS-1:0] m_w_ready,
  output axi_wr_pkg::b_m_t                 m_b        [axi_wr_pkg::N_MASTERS],
  output logic [axi_wr_pkg::N_MASTERS-1:0] m_b_valid,
  input  logic [axi_wr_pkg::N_MASTERS-1:0] m_b_ready,
  // External slaves 0 and 1
  output axi_wr_pkg::aw_s_t                s_aw       [axi_wr_pkg::N_SLAVES-1],
  output logic [axi_wr_pkg::N_SLAVES-2:0]  s_aw_valid,
  input  logic [axi_wr_pkg::N_SLAVES-2:0]  s_aw_ready,
  output axi_wr_pkg::w_t                   s_w        [axi_wr_pkg::N_SLAVES-1],
  output logic [axi_wr_pkg::N_SLAVES-2:0]  s_w_valid,
  input  logic [axi_wr_pkg::N_SLAVES-2:0]  s_w_ready,
  input  axi_wr_pkg::b_s_t                 s_b        [axi_wr_pkg::N_SLAVES-1],
  input  logic [axi_wr_pkg::N_SLAVES-2:0]  s_b_valid,
  output logic [axi_wr_pkg::N_SLAVES-2:0]  s_b_ready
);
  import axi_wr_pkg::*;

  aw_s_t                arb_aw;
  w_t                   arb_w;
  logic [N_SLAVES-1:0]  aw_req;
  logic [N_SLAVES-1:0]  aw_ack;
  logic [N_SLAVES-1:0]  w_req;
  logic [N_SLAVES-1:0]  w_ack;
  logic [N_MASTERS-1:0] b_done;

  // Slave side of every port, the last one is the default slave
  aw_s_t               p_aw [N_SLAVES];
  logic [N_SLAVES-1:0] p_aw_valid;
  logic [N_SLAVES-1:0] p_aw_ready;
  w_t                  p_w  [N_SLAVES];
  logic [N_SLAVES-1:0] p_w_valid;
  logic [N_SLAVES-1:0] p_w_ready;
  b_s_t                p_b  [N_SLAVES];
  logic [N_SLAVES-1:0] p_b_valid;
  logic [N_SLAVES-1:0] p_b_ready;

  // Port to b_return
  b_s_t                up_b [N_SLAVES];
  logic [N_SLAVES-1:0] up_b_valid;
  logic [N_SLAVES-1:0] up_b_ready;

  aw_arbiter u_arb (
    .clk        (clk),
    .rstn       (rstn),
    .m_aw       (m_aw),
    .m_aw_valid (m_aw_valid),
    .m_aw_ready (m_aw_ready),
    .m_w        (m_w),
    .m_w_valid  (m_w_valid),
    .m_w_ready  (m_w_ready),
    .b_done     (b_done),
    .aw_out     (arb_aw),
    .aw_req     (aw_req),
    .aw_ack     (aw_ack),
    .w_out      (arb_w),
    .w_req      (w_req),
    .w_ack      (w_ack)
  );

  for (genvar i = 0; i < N_SLAVES; i++) begin : g_port
    slave_port u_port (
      .clk        (clk),
      .rstn       (rstn),
      .aw_in      (arb_aw),
      .aw_req     (aw_req[i]),
      .aw_ack     (aw_ack[i]),
      .w_in       (arb_w),
      .w_req      (w_req[i]),
      .w_ack      (w_ack[i]),
      .s_aw       (p_aw[i]),
      .s_aw_valid (p_aw_valid[i]),
      .s_aw_ready (p_aw_ready[i]),
      .s_w        (p_w[i]),
      .s_w_valid  (p_w_valid[i]),
      .s_w_ready  (p_w_ready[i]),
      .s_b        (p_b[i]),
      .s_b_valid  (p_b_valid[i]),
      .s_b_ready  (p_b_ready[i]),
      .b_out      (up_b[i]),
      .b_valid    (up_b_valid[i]),
      .b_ready    (up_b_ready[i])
    );

    if (i < N_SLAVES - 1) begin : g_ext
      assign s_aw[i]       = p_aw[i];
      assign s_aw_valid[i] = p_aw_valid[i];
      assign p_aw_ready[i] = s_aw_ready[i];
      assign s_w[i]        = p_w[i];
      assign s_w_valid[i]  = p_w_valid[i];
      assign p_w_ready[i]  = s_w_ready[i];
      assign p_b[i]        = s_b[i];
      assign p_b_valid[i]  = s_b_valid[i];
      assign s_b_ready[i]  = p_b_ready[i];
    end
  end

  default_slave u_dflt (
    .clk      (clk),
    .rstn     (rstn),
    .aw       (p_aw[N_SLAVES-1]),
    .aw_valid (p_aw_valid[N_SLAVES-1]),
    .aw_ready (p_aw_ready[N_SLAVES-1]),
    .w        (p_w[N_SLAVES-1]),
    .w_valid  (p_w_valid[N_SLAVES-1]),
    .w_ready  (p_w_ready[N_SLAVES-1]),
    .b        (p_b[N_SLAVES-1]),
    .b_valid  (p_b_valid[N_SLAVES-1]),
    .b_ready  (p_b_ready[N_SLAVES-1])
  );

  b_return u_bret (
    .clk         (clk),
    .rstn        (rstn),
    .b_in        (up_b),
    .b_valid_in  (up_b_valid),
    .b_ready_out (up_b_ready),
    .m_b         (m_b),
    .m_b_valid   (m_b_valid),
    .m_b_ready   (m_b_ready),
    .b_done      (b_done)
  );

endmodule

//--- hw/b_return.sv
module b_return (
  input  logic                             clk,
  input  logic                             rstn,
  input  axi_wr_pkg::b_s_t                 b_in        [axi_wr_pkg::N_SLAVES],
  input  logic [axi_wr_pkg::N_SLAVES-1:0]  b_valid_in,
  output logic [axi_wr_pkg::N_SLAVES-1:0]  b_ready_out,
  output axi_wr_pkg::b_m_t                 m_b         [axi_wr_pkg::N_MASTERS],
  output logic [axi_wr_pkg::N_MASTERS-1:0] m_b_valid,
  input  logic [axi_wr_pkg::N_MASTERS-1:0] m_b_ready,
  output logic [axi_wr_pkg::N_MASTERS-1:0] b_done
);
  import axi_wr_pkg::*;

  slave_sel_t           sel   [N_MASTERS];
  slave_sel_t           sel_q [N_MASTERS];
  logic [N_MASTERS-1:0] found;
  logic [N_MASTERS-1:0] hold_q;

  // Lowest port index wins, scan runs downward
  always_comb begin
    for (int m = 0; m < N_MASTERS; m++) begin
      found[m] = 1'b0;
      sel[m]   = '0;
      for (int s = N_SLAVES - 1; s >= 0; s--) begin
        if (b_valid_in[s] && int'(b_in[s].id[IDS_W-1]) == m) begin
          found[m] = 1'b1;
          sel[m]   = slave_sel_t'(s);
        end
      end
      // A stalled response keeps its port
      if (hold_q[m]) begin
        sel[m] = sel_q[m];
      end
      m_b_valid[m] = found[m];
      m_b[m].id    = b_in[sel[m]].id[ID_W-1:0];
      m_b[m].resp  = b_in[sel[m]].resp;
      b_done[m]    = m_b_valid[m] & m_b_ready[m];
    end
  end

  always_comb begin
    b_ready_out = '0;
    for (int m = 0; m < N_MASTERS; m++) begin
      if (b_done[m]) begin
        b_ready_out[sel[m]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      hold_q <= '0;
    end else begin
      hold_q <= m_b_valid & ~m_b_ready;
    end
  end

  always_ff @(posedge clk) begin
    for (int m = 0; m < N_MASTERS; m++) begin
      if (m_b_valid[m] && !hold_q[m]) begin
        sel_q[m] <= sel[m];
      end
    end
  end

endmodule

//--- hw/default_slave.sv
module default_slave (
  input  logic              clk,
  input  logic              rstn,
  input  axi_wr_pkg::aw_s_t aw,
  input  logic              aw_valid,
  output logic              aw_ready,
  input  axi_wr_pkg::w_t    w,
  input  logic              w_valid,
  output logic              w_ready,
  output axi_wr_pkg::b_s_t  b,
  output logic              b_valid,
  input  logic              b_ready
);
  import axi_wr_pkg::*;

  axi_ids_t id_q;
  logic     aw_busy;
  logic     aw_hs;
  logic     w_last_hs;

  // One write at a time, address first
  assign aw_ready  = ~aw_busy & ~b_valid;
  assign w_ready   = aw_busy;
  assign aw_hs     = aw_valid & aw_ready;
  assign w_last_hs = w_valid & w_ready & w.last;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      aw_busy <= 1'b0;
    end else if (aw_hs) begin
      aw_busy <= 1'b1;
    end else if (w_last_hs) begin
      aw_busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      id_q <= aw.id;
    end
  end

  // Response the cycle after the last beat
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      b_valid <= 1'b0;
    end else if (w_last_hs) begin
      b_valid <= 1'b1;
    end else if (b_ready) begin
      b_valid <= 1'b0;
    end
  end

  assign b.id   = id_q;
  assign b.resp = RESP_DECERR;

endmodule

//--- hw/slave_port.sv
module slave_port (
  input  logic                 clk,
  input  logic                 rstn,
  // From the arbiter
  input  axi_wr_pkg::aw_s_t    aw_in,
  input  logic                 aw_req,
  output logic                 aw_ack,
  input  axi_wr_pkg::w_t       w_in,
  input  logic                 w_req,
  output logic                 w_ack,
  // Slave side
  output axi_wr_pkg::aw_s_t    s_aw,
  output logic                 s_aw_valid,
  input  logic                 s_aw_ready,
  output axi_wr_pkg::w_t       s_w,
  output logic                 s_w_valid,
  input  logic                 s_w_ready,
  input  axi_wr_pkg::b_s_t     s_b,
  input  logic                 s_b_valid,
  output logic                 s_b_ready,
  // Toward b_return
  output axi_wr_pkg::b_s_t     b_out,
  output logic                 b_valid,
  input  logic                 b_ready
);
  import axi_wr_pkg::*;

  aw_s_t aw_q;
  logic  aw_full;
  logic  w_own;
  logic  w_last_hs;

  // New request only when the register is empty and no burst is open
  assign aw_ack    = aw_req & ~aw_full & ~w_own;
  assign w_last_hs = w_ack & w_in.last;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      aw_full <= 1'b0;
    end else if (aw_ack) begin
      aw_full <= 1'b1;
    end else if (s_aw_ready) begin
      aw_full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (aw_ack) begin
      aw_q <= aw_in;
    end
  end

  // Burst ownership runs from AW accept to the WLAST beat
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      w_own <= 1'b0;
    end else if (aw_ack) begin
      w_own <= 1'b1;
    end else if (w_last_hs) begin
      w_own <= 1'b0;
    end
  end

  assign s_aw       = aw_q;
  assign s_aw_valid = aw_full;

  assign s_w       = w_in;
  assign s_w_valid = w_req & w_own;
  assign w_ack     = s_w_valid & s_w_ready;

  // B goes up untouched
  assign b_out     = s_b;
  assign b_valid   = s_b_valid;
  assign s_b_ready = b_ready;

endmodule

//--- hw/aw_arbiter.sv
module aw_arbiter (
  input  logic                                clk,
  input  logic                                rstn,
  // Master side
  input  axi_wr_pkg::aw_m_t                   m_aw       [axi_wr_pkg::N_MASTERS],
  input  logic [axi_wr_pkg::N_MASTERS-1:0]    m_aw_valid,
  output logic [axi_wr_pkg::N_MASTERS-1:0]    m_aw_ready,
  input  axi_wr_pkg::w_t                      m_w        [axi_wr_pkg::N_MASTERS],
  input  logic [axi_wr_pkg::N_MASTERS-1:0]    m_w_valid,
  output logic [axi_wr_pkg::N_MASTERS-1:0]    m_w_ready,
  input  logic [axi_wr_pkg::N_MASTERS-1:0]    b_done,
  // Toward the slave ports
  output axi_wr_pkg::aw_s_t                   aw_out,
  output logic [axi_wr_pkg::N_SLAVES-1:0]     aw_req,
  input  logic [axi_wr_pkg::N_SLAVES-1:0]     aw_ack,
  output axi_wr_pkg::w_t                      w_out,
  output logic [axi_wr_pkg::N_SLAVES-1:0]     w_req,
  input  logic [axi_wr_pkg::N_SLAVES-1:0]     w_ack
);
  import axi_wr_pkg::*;

  arb_lock_t            lock;
  arb_lock_t            lock_next;
  logic                 gnt_m;
  slave_sel_t           gnt_sel;
  logic                 rr_ptr;
  logic                 pick;
  logic [N_MASTERS-1:0] cand;
  logic [N_MASTERS-1:0] outstanding;
  logic                 aw_hs;
  logic                 w_last_hs;

  // Only masters without a write in flight may compete
  assign cand = m_aw_valid & ~outstanding;
  assign pick = cand[rr_ptr] ? rr_ptr : ~rr_ptr;

  assign aw_hs     = (lock == LOCK_AW) && |(aw_req & aw_ack);
  assign w_last_hs = (lock == LOCK_W) && |(w_req & w_ack) && w_out.last;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      lock   <= LOCK_FREE;
      gnt_m  <= 1'b0;
      rr_ptr <= 1'b0;
    end else begin
      lock <= lock_next;
      if (lock == LOCK_FREE && |cand) begin
        gnt_m  <= pick;
        rr_ptr <= ~pick;
      end
    end
  end

  // Target is decoded once, when the grant is taken
  always_ff @(posedge clk) begin
    if (lock == LOCK_FREE && |cand) begin
      gnt_sel <= addr_decode(m_aw[pick].addr);
    end
  end

  always_comb begin
    case (lock)
      LOCK_FREE: lock_next = (|cand) ? LOCK_AW : LOCK_FREE;
      LOCK_AW:   lock_next = aw_hs ? LOCK_W : LOCK_AW;
      LOCK_W:    lock_next = w_last_hs ? LOCK_FREE : LOCK_W;
      default:   lock_next = LOCK_FREE;
    endcase
  end

  // Held until the B response for this master comes back
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      outstanding <= '0;
    end else begin
      for (int m = 0; m < N_MASTERS; m++) begin
        if (m_aw_valid[m] && m_aw_ready[m]) begin
          outstanding[m] <= 1'b1;
        end else if (b_done[m]) begin
          outstanding[m] <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    aw_out.id    = {gnt_m, m_aw[gnt_m].id};
    aw_out.addr  = m_aw[gnt_m].addr;
    aw_out.len   = m_aw[gnt_m].len;
    aw_out.size  = m_aw[gnt_m].size;
    aw_out.burst = m_aw[gnt_m].burst;
    w_out        = m_w[gnt_m];

    aw_req     = '0;
    w_req      = '0;
    m_aw_ready = '0;
    m_w_ready  = '0;

    case (lock)
      LOCK_AW: begin
        aw_req[gnt_sel]   = m_aw_valid[gnt_m] & ~outstanding[gnt_m];
        m_aw_ready[gnt_m] = aw_ack[gnt_sel] & ~outstanding[gnt_m];
      end
      LOCK_W: begin
        w_req[gnt_sel]   = m_w_valid[gnt_m];
        m_w_ready[gnt_m] = w_ack[gnt_sel];
      end
      default: ;
    endcase
  end

endmodule

//--- hw/axi_wr_pkg.sv
package axi_wr_pkg;

  localparam int N_MASTERS = 2;
  localparam int N_SLAVES  = 3;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int ID_W   = 4;
  // Slave side carries the master index on top
  localparam int IDS_W  = 5;
  localparam int LEN_W  = 8;
  localparam int SIZE_W = 3;

  typedef logic [ADDR_W-1:0] axi_addr_t;
  typedef logic [DATA_W-1:0] axi_data_t;
  typedef logic [ID_W-1:0]   axi_id_t;
  typedef logic [IDS_W-1:0]  axi_ids_t;
  typedef logic [LEN_W-1:0]  axi_len_t;
  typedef logic [SIZE_W-1:0] axi_size_t;
  typedef logic [1:0]        axi_burst_t;
  typedef logic [1:0]        axi_resp_t;
  typedef logic [1:0]        slave_sel_t;

  // Address map, 64 KB per external slave
  localparam axi_addr_t SLV0_BASE = 32'h0000_0000;
  localparam axi_addr_t SLV1_BASE = 32'h0001_0000;
  localparam axi_addr_t SLV_MASK  = 32'h0000_FFFF;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_DECERR = 2'b11;

  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } aw_m_t;

  typedef struct packed {
    axi_ids_t   id;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } aw_s_t;

  typedef struct packed {
    axi_data_t data;
    logic      last;
  } w_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } b_m_t;

  typedef struct packed {
    axi_ids_t  id;
    axi_resp_t resp;
  } b_s_t;

  typedef enum logic [1:0] {
    LOCK_FREE,
    LOCK_AW,
    LOCK_W
  } arb_lock_t;

  // Unmapped space falls through to the default slave
  function automatic slave_sel_t addr_decode(input axi_addr_t addr);
    slave_sel_t sel;
    if ((addr & ~SLV_MASK) == SLV0_BASE) begin
      sel = slave_sel_t'(0);
    end else if ((addr & ~SLV_MASK) == SLV1_BASE) begin
      sel = slave_sel_t'(1);
    end else begin
      sel = slave_sel_t'(N_SLAVES - 1);
    end
    return sel;
  endfunction

endpackage
